// File: logic/analog_pkg.sv
/* widths of samples, gains and credit counters of the fast analog path,
   saturation limits of a calibrated sample */

package analog_pkg;

  ////////////////////////////////////////////////////////////
  // sample format
  ////////////////////////////////////////////////////////////

  // ADC, DAC and calibrated samples share one width
  localparam int SMP_W = 14;

  // limits of a signed SMP_W sample
  localparam int SMP_MAX = 8191;   // 2**(SMP_W-1) - 1
  localparam int SMP_MIN = -8192;  // -2**(SMP_W-1)

  ////////////////////////////////////////////////////////////
  // calibration
  ////////////////////////////////////////////////////////////

  // signed gain word
  localparam int MUL_W = 16;

  // gain fraction bits, 16384 is unity
  localparam int MUL_FRAC = 14;

  ////////////////////////////////////////////////////////////
  // flow control
  ////////////////////////////////////////////////////////////

  // credit counters, enough for depths up to 16
  localparam int CRD_W = 5;

endpackage : analog_pkg

// File: logic/sample_stream_if.sv
/* two-channel sample link with credit return,
   sender and receiver modports */

interface sample_stream_if;

  import analog_pkg::*;

  logic                    vld;    // one channel pair this cycle
  logic signed [SMP_W-1:0] dat_a;  // channel A sample
  logic signed [SMP_W-1:0] dat_b;  // channel B sample
  logic                    crd;    // one credit back to the sender

  // sender side, spends credits
  modport tx (
    output vld,
    output dat_a,
    output dat_b,
    input  crd
  );

  // receiver side, returns credits
  modport rx (
    input  vld,
    input  dat_a,
    input  dat_b,
    output crd
  );

endinterface : sample_stream_if

// File: logic/linear_cal.sv
/* one-channel gain and offset calibration, saturated,
   product stage then shift/offset stage */

module linear_cal (
  input  logic                              adc_clk,
  input  logic                              rst_n_i,
  input  logic signed [analog_pkg::SMP_W-1:0] dat_i,  // raw signed sample
  input  logic signed [analog_pkg::MUL_W-1:0] mul_i,  // gain, MUL_FRAC fraction bits
  input  logic signed [analog_pkg::SMP_W-1:0] sum_i,  // offset
  output logic signed [analog_pkg::SMP_W-1:0] dat_o   // calibrated sample
);

  import analog_pkg::*;

  localparam int PRD_W = SMP_W + MUL_W;     // full product
  localparam int SHF_W = PRD_W - MUL_FRAC;  // product after dropping fraction

  logic signed [PRD_W-1:0] prd_r;  // stage 1 product
  logic signed [SHF_W-1:0] shf_w;  // integer part of product
  logic signed [SHF_W:0]   acc_w;  // one extra bit for the offset add

  ////////////////////////////////////////////////////////////
  // stage 1, multiply
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      prd_r <= '0;
    end
    else
    begin
      prd_r <= dat_i * mul_i;  // signed, full width
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2, shift, offset, saturate
  ////////////////////////////////////////////////////////////

  // dropping low bits of a two's complement word rounds toward minus infinity
  assign shf_w = prd_r[PRD_W-1:MUL_FRAC];
  assign acc_w = shf_w + sum_i;  // sign extended to SHF_W+1

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dat_o <= '0;
    end
    else if (acc_w > SMP_MAX)
    begin
      dat_o <= SMP_W'(SMP_MAX);  // clip high
    end
    else if (acc_w < SMP_MIN)
    begin
      dat_o <= SMP_W'(SMP_MIN);  // clip low
    end
    else
    begin
      dat_o <= acc_w[SMP_W-1:0];
    end
  end

endmodule : linear_cal

// File: logic/adc_capture.sv
/* ADC input register, offset-binary to two's complement, ADC calibration,
   credit counter toward the sample FIFO and overflow count */

module adc_capture #(
  parameter int FIFO_DEPTH = 16  // credits granted by the FIFO
) (
  input  logic                                adc_clk,
  input  logic                                rst_n_i,
  input  logic                                adc_vld_i,
  input  logic        [analog_pkg::SMP_W-1:0] adc_a_i,  // unsigned, negative slope
  input  logic        [analog_pkg::SMP_W-1:0] adc_b_i,
  input  logic signed [analog_pkg::MUL_W-1:0] mul_a_i,
  input  logic signed [analog_pkg::MUL_W-1:0] mul_b_i,
  input  logic signed [analog_pkg::SMP_W-1:0] sum_a_i,
  input  logic signed [analog_pkg::SMP_W-1:0] sum_b_i,
  output logic        [15:0]                  ovf_cnt_o,  // dropped samples
  sample_stream_if.tx                         cap_link
);

  import analog_pkg::*;

  logic signed [SMP_W-1:0] raw_a_r;  // two's complement after input reg
  logic signed [SMP_W-1:0] raw_b_r;
  logic        [2:0]       vld_p;    // input reg, cal stage 1, cal stage 2
  logic        [CRD_W-1:0] crd_cnt;  // free FIFO entries

  ////////////////////////////////////////////////////////////
  // input register and format conversion
  ////////////////////////////////////////////////////////////

  // keep msb, invert the rest
  always_ff @(posedge adc_clk)
  begin
    raw_a_r <= {adc_a_i[SMP_W-1], ~adc_a_i[SMP_W-2:0]};
    raw_b_r <= {adc_b_i[SMP_W-1], ~adc_b_i[SMP_W-2:0]};
  end

  // valid travels beside the cal pipe
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      vld_p <= '0;
    else
      vld_p <= {vld_p[1:0], adc_vld_i};
  end

  linear_cal u_cal_a (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .dat_i   (raw_a_r),
    .mul_i   (mul_a_i),
    .sum_i   (sum_a_i),
    .dat_o   (cap_link.dat_a)
  );

  linear_cal u_cal_b (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .dat_i   (raw_b_r),
    .mul_i   (mul_b_i),
    .sum_i   (sum_b_i),
    .dat_o   (cap_link.dat_b)
  );

  ////////////////////////////////////////////////////////////
  // credits and drops
  ////////////////////////////////////////////////////////////

  assign cap_link.vld = vld_p[2] && (crd_cnt != '0);  // send only with a credit

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      crd_cnt   <= CRD_W'(FIFO_DEPTH);
      ovf_cnt_o <= '0;
    end
    else
    begin
      case ({cap_link.vld, cap_link.crd})
        2'b10:   crd_cnt <= crd_cnt - CRD_W'(1);  // spent
        2'b01:   crd_cnt <= crd_cnt + CRD_W'(1);  // returned
        default: crd_cnt <= crd_cnt;              // none, or both cancel
      endcase
      if (vld_p[2] && (crd_cnt == '0))
        ovf_cnt_o <= ovf_cnt_o + 16'd1;  // sample lost, FIFO full
    end
  end

endmodule : adc_capture

// File: logic/sample_fifo.sv
/* circular sample buffer fed by credits, forwards the head entry
   against the output stage's credits */

module sample_fifo #(
  parameter int FIFO_DEPTH = 16,  // entries, also credits given upstream
  parameter int OUT_DEPTH  = 2    // credits granted by the output stage
) (
  input  logic        adc_clk,
  input  logic        rst_n_i,
  sample_stream_if.rx wr,  // from capture
  sample_stream_if.tx rd   // to output stage
);

  import analog_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic signed [SMP_W-1:0] mem_a [FIFO_DEPTH];  // channel A storage
  logic signed [SMP_W-1:0] mem_b [FIFO_DEPTH];  // channel B storage
  logic        [PTR_W-1:0] wr_ptr;
  logic        [PTR_W-1:0] rd_ptr;
  logic        [CRD_W-1:0] fill;     // entries held
  logic        [CRD_W-1:0] out_crd;  // credits from output stage
  logic                    fwd;      // head leaves this cycle

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (wr.vld)
    begin
      mem_a[wr_ptr] <= wr.dat_a;
      mem_b[wr_ptr] <= wr.dat_b;
    end
  end

  ////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////

  // fill only counts a write after the edge, so a word waits one cycle
  assign fwd = (fill != '0) && (out_crd != '0);

  assign rd.vld   = fwd;
  assign rd.dat_a = mem_a[rd_ptr];
  assign rd.dat_b = mem_b[rd_ptr];
  assign wr.crd   = fwd;  // freed entry goes back upstream

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      out_crd <= CRD_W'(OUT_DEPTH);
    end
    else
    begin
      if (wr.vld)  // depth need not be a power of two
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      if (fwd)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);

      case ({wr.vld, fwd})
        2'b10:   fill <= fill + CRD_W'(1);
        2'b01:   fill <= fill - CRD_W'(1);
        default: fill <= fill;
      endcase

      case ({rd.vld, rd.crd})
        2'b10:   out_crd <= out_crd - CRD_W'(1);
        2'b01:   out_crd <= out_crd + CRD_W'(1);
        default: out_crd <= out_crd;  // idle or spend and return together
      endcase
    end
  end

endmodule : sample_fifo

// File: logic/dac_output.sv
/* generator sum with saturation, DAC calibration, conversion to the DAC
   format and the output queue that returns credits on each transfer */

module dac_output #(
  parameter int OUT_DEPTH = 2  // queue entries, also credits given upstream
) (
  input  logic                                adc_clk,
  input  logic                                rst_n_i,
  input  logic signed [analog_pkg::SMP_W-1:0] gen_a_i,  // held generator value
  input  logic signed [analog_pkg::SMP_W-1:0] gen_b_i,
  input  logic signed [analog_pkg::MUL_W-1:0] mul_a_i,
  input  logic signed [analog_pkg::MUL_W-1:0] mul_b_i,
  input  logic signed [analog_pkg::SMP_W-1:0] sum_a_i,
  input  logic signed [analog_pkg::SMP_W-1:0] sum_b_i,
  input  logic                                dac_rdy_i,
  output logic        [analog_pkg::SMP_W-1:0] dac_a_o,  // unsigned, negative slope
  output logic        [analog_pkg::SMP_W-1:0] dac_b_o,
  output logic                                dac_vld_o,
  sample_stream_if.rx                         out_link
);

  import analog_pkg::*;

  localparam int PTR_W = $clog2(OUT_DEPTH);

  logic signed [SMP_W:0]   add_a;  // one growth bit
  logic signed [SMP_W:0]   add_b;
  logic signed [SMP_W-1:0] sat_a_r;  // saturated sum register
  logic signed [SMP_W-1:0] sat_b_r;
  logic signed [SMP_W-1:0] cal_a;
  logic signed [SMP_W-1:0] cal_b;
  logic        [2:0]       vld_p;    // sum reg, cal stage 1, cal stage 2
  logic        [SMP_W-1:0] q_a [OUT_DEPTH];
  logic        [SMP_W-1:0] q_b [OUT_DEPTH];
  logic        [PTR_W-1:0] wr_ptr;
  logic        [PTR_W-1:0] rd_ptr;
  logic        [CRD_W-1:0] fill;
  logic                    pop;      // DAC takes the head

  ////////////////////////////////////////////////////////////
  // generator sum
  ////////////////////////////////////////////////////////////

  assign add_a = out_link.dat_a + gen_a_i;
  assign add_b = out_link.dat_b + gen_b_i;

  // top two bits differ on overflow, then clip toward the sign
  always_ff @(posedge adc_clk)
  begin
    sat_a_r <= (^add_a[SMP_W:SMP_W-1]) ? {add_a[SMP_W], {(SMP_W-1){~add_a[SMP_W]}}}
                                       : add_a[SMP_W-1:0];
    sat_b_r <= (^add_b[SMP_W:SMP_W-1]) ? {add_b[SMP_W], {(SMP_W-1){~add_b[SMP_W]}}}
                                       : add_b[SMP_W-1:0];
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      vld_p <= '0;
    else
      vld_p <= {vld_p[1:0], out_link.vld};
  end

  linear_cal u_cal_a (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .dat_i   (sat_a_r),
    .mul_i   (mul_a_i),
    .sum_i   (sum_a_i),
    .dat_o   (cal_a)
  );

  linear_cal u_cal_b (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .dat_i   (sat_b_r),
    .mul_i   (mul_b_i),
    .sum_i   (sum_b_i),
    .dat_o   (cal_b)
  );

  ////////////////////////////////////////////////////////////
  // output queue
  ////////////////////////////////////////////////////////////

  // stored already in DAC format, msb kept and the rest inverted
  always_ff @(posedge adc_clk)
  begin
    if (vld_p[2])
    begin
      q_a[wr_ptr] <= {cal_a[SMP_W-1], ~cal_a[SMP_W-2:0]};
      q_b[wr_ptr] <= {cal_b[SMP_W-1], ~cal_b[SMP_W-2:0]};
    end
  end

  assign dac_vld_o    = (fill != '0);
  assign dac_a_o      = q_a[rd_ptr];
  assign dac_b_o      = q_b[rd_ptr];
  assign pop          = dac_vld_o && dac_rdy_i;
  assign out_link.crd = pop;  // slot freed, credit back to the FIFO

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (vld_p[2])
        wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);

      case ({vld_p[2], pop})
        2'b10:   fill <= fill + CRD_W'(1);
        2'b01:   fill <= fill - CRD_W'(1);
        default: fill <= fill;
      endcase
    end
  end

endmodule : dac_output

// File: logic/analog_top.sv
/* two-channel fast analog path, ADC capture through sample FIFO
   to DAC output with calibration and generator sum */

module analog_top #(
  parameter int FIFO_DEPTH = 16,  // sample buffer entries
  parameter int OUT_DEPTH  = 2    // DAC output queue entries
) (
  input  logic                                adc_clk,
  input  logic                                rst_n_i,
  // ADC
  input  logic                                adc_vld_i,
  input  logic        [analog_pkg::SMP_W-1:0] adc_a_i,
  input  logic        [analog_pkg::SMP_W-1:0] adc_b_i,
  // calibration, gains
  input  logic signed [analog_pkg::MUL_W-1:0] adc_mul_a_i,
  input  logic signed [analog_pkg::MUL_W-1:0] adc_mul_b_i,
  input  logic signed [analog_pkg::MUL_W-1:0] dac_mul_a_i,
  input  logic signed [analog_pkg::MUL_W-1:0] dac_mul_b_i,
  // calibration, offsets
  input  logic signed [analog_pkg::SMP_W-1:0] adc_sum_a_i,
  input  logic signed [analog_pkg::SMP_W-1:0] adc_sum_b_i,
  input  logic signed [analog_pkg::SMP_W-1:0] dac_sum_a_i,
  input  logic signed [analog_pkg::SMP_W-1:0] dac_sum_b_i,
  // generator
  input  logic signed [analog_pkg::SMP_W-1:0] gen_a_i,
  input  logic signed [analog_pkg::SMP_W-1:0] gen_b_i,
  // DAC
  input  logic                                dac_rdy_i,
  output logic        [analog_pkg::SMP_W-1:0] dac_a_o,
  output logic        [analog_pkg::SMP_W-1:0] dac_b_o,
  output logic                                dac_vld_o,
  output logic        [15:0]                  ovf_cnt_o
);

  sample_stream_if cap_link ();  // capture to FIFO
  sample_stream_if out_link ();  // FIFO to DAC stage

  adc_capture #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_adc_capture (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_vld_i (adc_vld_i),
    .adc_a_i   (adc_a_i),
    .adc_b_i   (adc_b_i),
    .mul_a_i   (adc_mul_a_i),
    .mul_b_i   (adc_mul_b_i),
    .sum_a_i   (adc_sum_a_i),
    .sum_b_i   (adc_sum_b_i),
    .ovf_cnt_o (ovf_cnt_o),
    .cap_link  (cap_link.tx)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .OUT_DEPTH  (OUT_DEPTH)
  ) u_sample_fifo (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .wr      (cap_link.rx),
    .rd      (out_link.tx)
  );

  dac_output #(
    .OUT_DEPTH (OUT_DEPTH)
  ) u_dac_output (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .gen_a_i   (gen_a_i),
    .gen_b_i   (gen_b_i),
    .mul_a_i   (dac_mul_a_i),
    .mul_b_i   (dac_mul_b_i),
    .sum_a_i   (dac_sum_a_i),
    .sum_b_i   (dac_sum_b_i),
    .dac_rdy_i (dac_rdy_i),
    .dac_a_o   (dac_a_o),
    .dac_b_o   (dac_b_o),
    .dac_vld_o (dac_vld_o),
    .out_link  (out_link.rx)
  );

endmodule : analog_top

// File: verif/analog_tb.sv
/* testbench for the fast analog path, reference model, output monitor
   and the reset, unity, calibration, generator and back-pressure tests */

module analog_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import analog_pkg::*;

  localparam int CLK_HALF  = 4;     // 8 ns period
  localparam int DRAIN_MAX = 3000;  // cycles allowed for the path to empty

  logic                    adc_clk;
  logic                    rst_n_i;
  logic                    adc_vld_i;
  logic        [SMP_W-1:0] adc_a_i;
  logic        [SMP_W-1:0] adc_b_i;
  logic signed [MUL_W-1:0] adc_mul_a_i;
  logic signed [MUL_W-1:0] adc_mul_b_i;
  logic signed [MUL_W-1:0] dac_mul_a_i;
  logic signed [MUL_W-1:0] dac_mul_b_i;
  logic signed [SMP_W-1:0] adc_sum_a_i;
  logic signed [SMP_W-1:0] adc_sum_b_i;
  logic signed [SMP_W-1:0] dac_sum_a_i;
  logic signed [SMP_W-1:0] dac_sum_b_i;
  logic signed [SMP_W-1:0] gen_a_i;
  logic signed [SMP_W-1:0] gen_b_i;
  logic                    dac_rdy_i;
  logic        [SMP_W-1:0] dac_a_o;
  logic        [SMP_W-1:0] dac_b_o;
  logic                    dac_vld_o;
  logic        [15:0]      ovf_cnt_o;

  logic [2*SMP_W-1:0] exp_q[$];  // expected {a, b}, oldest first
  string       cur_test;
  logic [15:0] ovf_base;    // ovf_cnt_o at test start
  int          rdy_mode;    // 0 high, 1 low, 2 random
  bit          allow_drop;  // monitor may skip entries
  int          sent_cnt;
  int          rcv_cnt;
  int          skip_cnt;
  int          err_cnt;
  int          err_base;
  int          chk_cnt;
  int          test_cnt;
  int          fail_cnt;
  int unsigned seed_ret;

  analog_top u_analog_top (.*);  // default depths

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic int clip(int x);
    if (x > SMP_MAX)
      return SMP_MAX;
    if (x < SMP_MIN)
      return SMP_MIN;
    return x;
  endfunction

  // arithmetic shift floors, i.e. rounds toward minus infinity
  function automatic int calibrate(int x, int mul, int off);
    int prd;
    prd = x * mul;
    return clip((prd >>> MUL_FRAC) + off);
  endfunction

  function automatic logic [SMP_W-1:0] ref_sample(logic [SMP_W-1:0] raw, int amul,
                                                  int asum, int gen, int dmul, int dsum);
    logic [SMP_W-1:0] bits;
    int               val;
    bits = {raw[SMP_W-1], ~raw[SMP_W-2:0]};  // ADC word to two's complement
    val  = bits[SMP_W-1] ? int'(bits) - (1 << SMP_W) : int'(bits);
    val  = calibrate(val, amul, asum);
    val  = clip(val + gen);                   // generator sum
    val  = calibrate(val, dmul, dsum);
    bits = val[SMP_W-1:0];
    return {bits[SMP_W-1], ~bits[SMP_W-2:0]};  // back to DAC format
  endfunction

  function automatic logic [2*SMP_W-1:0] expect_pair(logic [SMP_W-1:0] a,
                                                     logic [SMP_W-1:0] b);
    return {ref_sample(a, adc_mul_a_i, adc_sum_a_i, gen_a_i, dac_mul_a_i, dac_sum_a_i),
            ref_sample(b, adc_mul_b_i, adc_sum_b_i, gen_b_i, dac_mul_b_i, dac_sum_b_i)};
  endfunction

  // gain magnitude above 1.2, random sign
  function automatic int big_gain();
    int g;
    g = 20000 + int'($urandom % 12768);
    return ($urandom % 2) ? -g : g;
  endfunction

  task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
    chk_cnt++;
    if (exp !== act)
    begin
      err_cnt++;
      $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // clock and monitor
  ////////////////////////////////////////////////////////////

  initial
  begin
    adc_clk = 1'b0;
    forever #CLK_HALF adc_clk = ~adc_clk;
  end

  task automatic take_word(logic [2*SMP_W-1:0] act);
    rcv_cnt++;
    if (allow_drop)  // dropped samples leave gaps
      while (exp_q.size() > 0 && exp_q[0] !== act)
      begin
        void'(exp_q.pop_front());
        skip_cnt++;
      end
    if (exp_q.size() == 0)
    begin
      err_cnt++;
      $display("test %s: DAC word %h arrived with nothing expected", cur_test, act);
    end
    else
      check_val("dac word", exp_q.pop_front(), act);
  endtask

  // sample mid low phase, inputs settled and outputs held
  initial
  begin
    forever
    begin
      @(negedge adc_clk);
      #2;
      if (rst_n_i && dac_vld_o && dac_rdy_i)
        take_word({dac_a_o, dac_b_o});
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // DAC ready for the coming cycle, called on the falling edge
  task automatic drive_rdy();
    case (rdy_mode)
      1:       dac_rdy_i = 1'b0;
      2:       dac_rdy_i = $urandom % 2;
      default: dac_rdy_i = 1'b1;
    endcase
  endtask

  task automatic send_one(bit en);
    @(negedge adc_clk);
    drive_rdy();
    adc_vld_i = en;
    adc_a_i   = SMP_W'($urandom);
    adc_b_i   = SMP_W'($urandom);
    if (en)
    begin
      exp_q.push_back(expect_pair(adc_a_i, adc_b_i));
      sent_cnt++;
    end
  endtask

  // one sample every 4 cycles, below the credit loop rate
  task automatic send_spaced(int n);
    repeat (n)
    begin
      send_one(1'b1);
      repeat (3) send_one(1'b0);
    end
  endtask

  task automatic stream(int cycles, int pct);
    repeat (cycles) send_one(($urandom % 100) < pct);
  endtask

  task automatic set_unity();
    adc_mul_a_i = 16384;
    adc_mul_b_i = 16384;
    dac_mul_a_i = 16384;
    dac_mul_b_i = 16384;
    adc_sum_a_i = '0;
    adc_sum_b_i = '0;
    dac_sum_a_i = '0;
    dac_sum_b_i = '0;
    gen_a_i     = '0;
    gen_b_i     = '0;
  endtask

  // every sample either came out or was counted as dropped
  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while (rcv_cnt + int'(ovf_cnt_o - ovf_base) < sent_cnt && cyc < DRAIN_MAX)
    begin
      @(negedge adc_clk);
      drive_rdy();
      adc_vld_i = 1'b0;
      cyc++;
    end
    if (cyc >= DRAIN_MAX)
    begin
      err_cnt++;
      $display("test %s: outputs still missing after %0d cycles", cur_test, DRAIN_MAX);
    end
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    err_base = err_cnt;
    sent_cnt = 0;
    rcv_cnt  = 0;
    skip_cnt = 0;
    ovf_base = ovf_cnt_o;
    exp_q.delete();
  endtask

  task automatic end_test();
    if (!allow_drop)
    begin
      check_val("dropped", 0, ovf_cnt_o - ovf_base);
      check_val("received", sent_cnt, rcv_cnt);
    end
    test_cnt++;
    if (err_cnt != err_base)
      fail_cnt++;
    $display("test %s: %s, %0d sent, %0d errors", cur_test,
             (err_cnt == err_base) ? "ok" : "failed", sent_cnt, err_cnt - err_base);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial
  begin
    int growth;
    seed_ret   = $urandom(32'hcfc9b4dc);
    rst_n_i    = 1'b0;
    adc_vld_i  = 1'b0;
    adc_a_i    = '0;
    adc_b_i    = '0;
    dac_rdy_i  = 1'b1;
    rdy_mode   = 0;
    allow_drop = 1'b0;
    set_unity();

    begin_test("reset");
    ovf_base = '0;  // drop counter value after reset
    repeat (2)
    begin
      @(negedge adc_clk);
      check_val("dac_vld_o", 0, dac_vld_o);
      check_val("ovf_cnt_o", 0, ovf_cnt_o);
    end
    rst_n_i = 1'b1;
    repeat (3)
    begin
      @(negedge adc_clk);
      check_val("dac_vld_o", 0, dac_vld_o);
      check_val("ovf_cnt_o", 0, ovf_cnt_o);
    end
    end_test();

    begin_test("unity");
    send_spaced(200);
    wait_drain();
    end_test();

    begin_test("calibration");
    adc_mul_a_i = MUL_W'(big_gain());
    adc_mul_b_i = MUL_W'(big_gain());
    dac_mul_a_i = MUL_W'(big_gain());
    dac_mul_b_i = MUL_W'(big_gain());
    adc_sum_a_i = SMP_W'($urandom);
    adc_sum_b_i = SMP_W'($urandom);
    dac_sum_a_i = SMP_W'($urandom);
    dac_sum_b_i = SMP_W'($urandom);
    send_spaced(200);
    wait_drain();
    end_test();

    begin_test("generator");
    set_unity();
    gen_a_i = 8100;   // near the top
    gen_b_i = -8100;  // near the bottom
    send_spaced(200);
    wait_drain();
    end_test();

    begin_test("backpressure");
    set_unity();
    allow_drop = 1'b1;
    rdy_mode   = 1;
    stream(60, 100);  // queue and FIFO fill, then drops
    rdy_mode   = 2;
    stream(120, 50);
    wait_drain();
    skip_cnt += exp_q.size();  // drops at the tail
    exp_q.delete();
    growth = int'(ovf_cnt_o - ovf_base);
    if (growth == 0)
    begin
      err_cnt++;
      $display("test %s: ovf_cnt_o did not grow under back-pressure", cur_test);
    end
    check_val("skipped", growth, skip_cnt);
    check_val("received", sent_cnt - growth, rcv_cnt);
    end_test();
    allow_drop = 1'b0;
    rdy_mode   = 0;

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, fail_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule : analog_tb

// File: vlog.f
logic/analog_pkg.sv
logic/sample_stream_if.sv
logic/linear_cal.sv
logic/adc_capture.sv
logic/sample_fifo.sv
logic/dac_output.sv
logic/analog_top.sv
verif/analog_tb.sv

// File: run.sh
#!/bin/sh
# build the analog path testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module analog_tb -f vlog.f -o analog_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/analog_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
